//--- Bender.yml
package:
  name: clock_display

sources:
  - target: rtl
    files:
      - verilog/clockDisplayPkg.sv
      - verilog/rasterCounter.sv
      - verilog/digitLocator.sv
      - verilog/segmentRaster.sv
      - verilog/clockDisplay.sv
  - target: verif
    files:
      - verif/clockDisplay_properties.sv
      - verif/clockDisplayTb.sv

//--- filelist.f
verilog/clockDisplayPkg.sv
verilog/rasterCounter.sv
verilog/digitLocator.sv
verilog/segmentRaster.sv
verilog/clockDisplay.sv
verif/clockDisplay_properties.sv
verif/clockDisplayTb.sv

//--- verif/clockDisplayTb.sv
`timescale 1ns/1ps
`default_nettype none

module clockDisplayTb;

   import clockDisplayPkg::*;

   localparam int clkPeriod = 10;
   // bars a..g in block units, inclusive bounds
   localparam int barX0 [7] = '{1, 4, 4, 1, 0, 0, 1};
   localparam int barX1 [7] = '{4, 5, 5, 4, 1, 1, 4};
   localparam int barY0 [7] = '{0, 1, 5, 8, 5, 1, 4};
   localparam int barY1 [7] = '{1, 4, 8, 9, 8, 4, 5};
   // per segment, bit d set when digit d lights it
   localparam logic [9:0] litBy [7] = '{10'b1111101101, 10'b1110011111, 10'b1111111011,
      10'b1101101101, 10'b0101000101, 10'b1101110001, 10'b1101111100};

   logic  clk;
   logic  h_Disp;
   digitT hourTens, hourUnits, minTens, minUnits, secTens, secUnits;
   coordT pixX, pixY;
   logic  rOut, gOut, bOut;

   int          numFrames = 0;
   logic [23:0] frameDigits [$];
   int          frameLit [$];
   int          curDigits [NumDigits];
   int          litCount;

   clockDisplay i_dut (.*);

   bind clockDisplay clockDisplay_properties #(.originX(originX), .lineTotal(lineTotal))
      i_props (.clk(clk), .h_Disp(h_Disp), .pixX(pixX), .rOut(rOut), .gOut(gOut), .bOut(bOut));

   initial begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   task automatic compareValue(input string name, input longint expected, input longint actual);
      if (expected != actual) begin
         $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
         $display("Simulation finished: FAIL");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   // reference pixel from the cell geometry and the segment table
   function automatic bit modelPixel(input int x, input int y);
      int dx, dy, slot, lx, s;
      bit on;
      on = 1'b0;
      dx = x - defaultOriginX;
      dy = y - defaultOriginY;
      if (dx >= 0 && dy >= 0 && dy <= 9 * defaultBlockSize) begin
         slot = dx / defaultDigitPitch;
         lx   = dx % defaultDigitPitch;
         // gap between cells stays dark
         if (slot < NumDigits && lx <= 5 * defaultBlockSize && curDigits[slot] < 10) begin
            for (s = 0; s < 7; s++) begin
               if (litBy[s][curDigits[slot]]
                     && lx >= barX0[s] * defaultBlockSize && lx <= barX1[s] * defaultBlockSize
                     && dy >= barY0[s] * defaultBlockSize && dy <= barY1[s] * defaultBlockSize)
                  on = 1'b1;
            end
         end
      end
      return on;
   endfunction

   task automatic checkPixel(input int x, input int y);
      bit expOn;
      expOn = modelPixel(x, y);
      compareValue("pixX", x, pixX);
      compareValue("pixY", y, pixY);
      compareValue("rOut", expOn, rOut);
      compareValue("gOut", expOn, gOut);
      compareValue("bOut", expOn, bOut);
      litCount += rOut;
   endtask

   task automatic checkBlackAtOrigin();
      compareValue("pixX", 0, pixX);
      compareValue("pixY", 0, pixY);
      compareValue("rOut", 0, rOut);
      compareValue("gOut", 0, gOut);
      compareValue("bOut", 0, bOut);
   endtask

   task automatic driveDigits(input int f);
      for (int s = 0; s < NumDigits; s++)
         curDigits[s] = frameDigits[f][23 - 4 * s -: 4];
      {hourTens, hourUnits, minTens, minUnits, secTens, secUnits} = frameDigits[f];
   endtask

   task automatic readGolden();
      int fd, n, cnt, rc;
      int d [6];
      string line;
      fd = $fopen("verif/golden_digits.txt", "r");
      if (fd == 0) begin
         $display("cannot open the golden digit file");
         $display("Simulation finished: FAIL");
         $fatal(1, "no golden file");
      end
      while (!$feof(fd)) begin
         line = "";
         rc = $fgets(line, fd);
         // comment and empty lines scan as fewer than seven fields
         n = $sscanf(line, "%h %h %h %h %h %h %d", d[0], d[1], d[2], d[3], d[4], d[5], cnt);
         if (rc > 0 && n == 7) begin
            frameDigits.push_back({d[0][3:0], d[1][3:0], d[2][3:0],
                                   d[3][3:0], d[4][3:0], d[5][3:0]});
            frameLit.push_back(cnt);
         end
      end
      $fclose(fd);
      numFrames = frameDigits.size();
   endtask

   // watchdog sized from the golden frame count
   initial begin
      wait (numFrames > 0);
      #((longint'(numFrames) * defaultLineTotal * defaultFrameTotal + 100) * clkPeriod);
      $display("watchdog expired before all golden frames were checked");
      $display("Simulation finished: FAIL");
      $fatal(1, "timeout");
   end

   initial begin
      h_Disp = 1'b1;
      {hourTens, hourUnits, minTens, minUnits, secTens, secUnits} = '0;
      readGolden();
      if (numFrames == 0) begin
         $display("the golden digit file holds no frames");
         $display("Simulation finished: FAIL");
         $fatal(1, "empty golden file");
      end
      driveDigits(0);
      repeat (8) @(negedge clk);
      h_Disp = 1'b0;
      // cleared stage three value comes out first
      @(negedge clk);
      checkBlackAtOrigin();
      for (int f = 0; f < numFrames; f++) begin
         litCount = 0;
         for (int y = 0; y < defaultFrameTotal; y++) begin
            for (int x = 0; x < defaultLineTotal; x++) begin
               @(negedge clk);
               checkPixel(x, y);
               // raster is in row 0 here, far above the digit rows
               if (x == 0 && y == 0)
                  driveDigits(f);
            end
         end
         compareValue("litCount", frameLit[f], litCount);
      end
      // second reset part way into the next frame
      for (int x = 0; x < 30; x++) begin
         @(negedge clk);
         checkPixel(x, 0);
      end
      h_Disp = 1'b1;
      #1;
      checkBlackAtOrigin();
      repeat (3) begin
         @(negedge clk);
         checkBlackAtOrigin();
      end
      h_Disp = 1'b0;
      @(negedge clk);
      checkBlackAtOrigin();
      // scan restarts from the top left
      for (int x = 0; x < 8; x++) begin
         @(negedge clk);
         checkPixel(x, 0);
      end
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- verif/clockDisplay_properties.sv
`timescale 1ns/1ps
`default_nettype none

module clockDisplay_properties #(
   parameter int originX   = clockDisplayPkg::defaultOriginX,
   parameter int lineTotal = clockDisplayPkg::defaultLineTotal
) (
   input wire                         clk,
   input wire                         h_Disp,
   input wire clockDisplayPkg::coordT pixX,
   input wire                         rOut,
   input wire                         gOut,
   input wire                         bOut
);

   import clockDisplayPkg::*;

   // white on black, all three guns together
   colorsEqual: assert property (@(posedge clk) (rOut == gOut) && (gOut == bOut))
      else $error("colour outputs differ");

   // glyph box starts at originX
   leftBlack: assert property (@(posedge clk) disable iff (h_Disp)
      (pixX < coordT'(originX)) |-> !rOut)
      else $error("pixel lit left of the glyph box");

   // cleared value, then position zero, keep pixX at zero for three samples
   scanStep: assert property (@(posedge clk) disable iff (h_Disp)
      ($past(!h_Disp) && $past(!h_Disp, 2) && $past(!h_Disp, 3)) |->
         (pixX == (($past(pixX) == coordT'(lineTotal - 1)) ? '0 : $past(pixX) + 1'b1)))
      else $error("pixX did not advance by one");

endmodule

`default_nettype wire

//--- verif/golden_digits.txt
// hourTens hourUnits minTens minUnits secTens secUnits (hex, a to f blank)
// last column: lit pixels expected in the frame (decimal)
0 1 2 3 4 5 2573
1 2 3 4 5 6 2571
2 3 4 5 6 7 2666
3 4 5 6 7 8 2854
4 5 6 7 8 9 2948
5 6 7 8 9 f 2567
6 7 8 9 e 0 2663
7 8 9 d 0 1 2285
8 9 c 0 1 2 2474
9 b 0 1 2 3 2286
a 0 1 2 3 4 2097

//--- verilog/clockDisplay.sv
`timescale 1ns/1ps
`default_nettype none

module clockDisplay #(
   parameter int lineTotal  = clockDisplayPkg::defaultLineTotal,
   parameter int frameTotal = clockDisplayPkg::defaultFrameTotal,
   parameter int originX    = clockDisplayPkg::defaultOriginX,
   parameter int originY    = clockDisplayPkg::defaultOriginY,
   parameter int blockSize  = clockDisplayPkg::defaultBlockSize,
   parameter int digitPitch = clockDisplayPkg::defaultDigitPitch
) (
   input  logic                   clk,
   input  logic                   h_Disp,
   input  clockDisplayPkg::digitT hourTens,
   input  clockDisplayPkg::digitT hourUnits,
   input  clockDisplayPkg::digitT minTens,
   input  clockDisplayPkg::digitT minUnits,
   input  clockDisplayPkg::digitT secTens,
   input  clockDisplayPkg::digitT secUnits,
   output clockDisplayPkg::coordT pixX,
   output clockDisplayPkg::coordT pixY,
   output logic                   rOut,
   output logic                   gOut,
   output logic                   bOut
);

   import clockDisplayPkg::*;

   // stage one to two
   coordT posX;
   coordT posY;
   // stage two to three
   coordT cellX;
   coordT cellY;
   digitT cellDigit;
   logic  inCell;
   coordT locX;
   coordT locY;
   // stage three result
   logic  pixOn;

   rasterCounter #(
      .lineTotal  (lineTotal),
      .frameTotal (frameTotal)
   ) i_raster (
      .clk    (clk),
      .h_Disp (h_Disp),
      .posX   (posX),
      .posY   (posY)
   );

   digitLocator #(
      .originX    (originX),
      .originY    (originY),
      .blockSize  (blockSize),
      .digitPitch (digitPitch)
   ) i_locator (
      .clk       (clk),
      .h_Disp    (h_Disp),
      .posX      (posX),
      .posY      (posY),
      .hourTens  (hourTens),
      .hourUnits (hourUnits),
      .minTens   (minTens),
      .minUnits  (minUnits),
      .secTens   (secTens),
      .secUnits  (secUnits),
      .cellX     (cellX),
      .cellY     (cellY),
      .cellDigit (cellDigit),
      .inCell    (inCell),
      .outX      (locX),
      .outY      (locY)
   );

   segmentRaster #(
      .blockSize (blockSize)
   ) i_segments (
      .clk       (clk),
      .h_Disp    (h_Disp),
      .cellX     (cellX),
      .cellY     (cellY),
      .cellDigit (cellDigit),
      .inCell    (inCell),
      .inX       (locX),
      .inY       (locY),
      .pixOn     (pixOn),
      .pixX      (pixX),
      .pixY      (pixY)
   );

   // white on black
   assign rOut = pixOn;
   assign gOut = pixOn;
   assign bOut = pixOn;

endmodule

`default_nettype wire

//--- verilog/clockDisplayPkg.sv
`default_nettype none

package clockDisplayPkg;

   // raster coordinate, wide enough for 800 columns
   typedef logic [10:0] coordT;

   // one bcd digit, 10 to 15 show as blank
   typedef logic [3:0] digitT;

   // bit 6 is segment a, bit 0 is segment g
   typedef logic [6:0] segMaskT;

   // segment names as bit positions in segMaskT
   typedef enum logic [2:0] {
      segA = 3'd6,
      segB = 3'd5,
      segC = 3'd4,
      segD = 3'd3,
      segE = 3'd2,
      segF = 3'd1,
      segG = 3'd0
   } segIdT;

   // digit slot, 0 is hour tens, 5 is second units
   typedef logic [2:0] slotT;

   localparam int NumDigits = 6;

   // scan totals
   localparam int defaultLineTotal  = 800;
   localparam int defaultFrameTotal = 525;

   // glyph placement, all in pixels
   localparam int defaultOriginX    = 400;
   localparam int defaultOriginY    = 217;
   localparam int defaultBlockSize  = 5;
   // must exceed five blocks so cells never overlap
   localparam int defaultDigitPitch = 30;

endpackage

`default_nettype wire

//--- verilog/digitLocator.sv
`timescale 1ns/1ps
`default_nettype none

module digitLocator #(
   parameter int originX    = clockDisplayPkg::defaultOriginX,
   parameter int originY    = clockDisplayPkg::defaultOriginY,
   parameter int blockSize  = clockDisplayPkg::defaultBlockSize,
   parameter int digitPitch = clockDisplayPkg::defaultDigitPitch
) (
   input  logic                   clk,
   input  logic                   h_Disp,
   input  clockDisplayPkg::coordT posX,
   input  clockDisplayPkg::coordT posY,
   input  clockDisplayPkg::digitT hourTens,
   input  clockDisplayPkg::digitT hourUnits,
   input  clockDisplayPkg::digitT minTens,
   input  clockDisplayPkg::digitT minUnits,
   input  clockDisplayPkg::digitT secTens,
   input  clockDisplayPkg::digitT secUnits,
   output clockDisplayPkg::coordT cellX,
   output clockDisplayPkg::coordT cellY,
   output clockDisplayPkg::digitT cellDigit,
   output logic                   inCell,
   output clockDisplayPkg::coordT outX,
   output clockDisplayPkg::coordT outY
);

   import clockDisplayPkg::*;

   // cell is five blocks wide, nine tall, bounds inclusive
   localparam coordT cellW  = coordT'(5 * blockSize);
   localparam coordT rowTop = coordT'(originY);
   localparam coordT rowBot = coordT'(originY + 9 * blockSize);

   digitT digitVal [NumDigits];
   logic  rowHit;
   logic  hit;
   slotT  hitSlot;

   // a pixel may belong to two cells otherwise
   if (digitPitch <= 5 * blockSize) begin : g_pitchCheck
      $error("digit pitch must be larger than the cell width");
   end

   // left edge of a slot
   function automatic coordT slotOrigin(input slotT slot);
      return coordT'(originX + slot * digitPitch);
   endfunction

   // slot order, hour tens first
   assign digitVal[0] = hourTens;
   assign digitVal[1] = hourUnits;
   assign digitVal[2] = minTens;
   assign digitVal[3] = minUnits;
   assign digitVal[4] = secTens;
   assign digitVal[5] = secUnits;

   // all slots share one row band
   assign rowHit = (posY >= rowTop) && (posY <= rowBot);

   // at most one slot can match
   always_comb begin
      hit     = 1'b0;
      hitSlot = '0;
      for (int s = 0; s < NumDigits; s++) begin
         if (rowHit && (posX >= slotOrigin(slotT'(s)))
               && (posX <= slotOrigin(slotT'(s)) + cellW)) begin
            hit     = 1'b1;
            hitSlot = slotT'(s);
         end
      end
   end

   always_ff @(posedge clk or posedge h_Disp) begin
      if (h_Disp) begin
         inCell    <= 1'b0;
         cellDigit <= '0;
         cellX     <= '0;
         cellY     <= '0;
         outX      <= '0;
         outY      <= '0;
      end else begin
         inCell <= hit;
         // digit inputs sampled here
         cellDigit <= hit ? digitVal[hitSlot] : '0;
         // local coordinate, zero outside any cell
         cellX <= hit ? posX - slotOrigin(hitSlot) : '0;
         cellY <= hit ? posY - rowTop : '0;
         // coordinate follows its pixel
         outX <= posX;
         outY <= posY;
      end
   end

endmodule

`default_nettype wire

//--- verilog/rasterCounter.sv
`timescale 1ns/1ps
`default_nettype none

module rasterCounter #(
   parameter int lineTotal  = clockDisplayPkg::defaultLineTotal,
   parameter int frameTotal = clockDisplayPkg::defaultFrameTotal
) (
   input  logic                  clk,
   input  logic                  h_Disp,
   output clockDisplayPkg::coordT posX,
   output clockDisplayPkg::coordT posY
);

   import clockDisplayPkg::*;

   // last column and last line of the scan
   localparam coordT lastX = coordT'(lineTotal - 1);
   localparam coordT lastY = coordT'(frameTotal - 1);

   // self-timed scan, no external strobes
   always_ff @(posedge clk or posedge h_Disp) begin
      if (h_Disp) begin
         posX <= '0;
         posY <= '0;
      end else if (posX == lastX) begin
         // end of line
         posX <= '0;
         if (posY == lastY) begin
            // end of frame, back to the top
            posY <= '0;
         end else begin
            posY <= posY + 1'b1;
         end
      end else begin
         posX <= posX + 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- verilog/segmentRaster.sv
`timescale 1ns/1ps
`default_nettype none

module segmentRaster #(
   parameter int blockSize = clockDisplayPkg::defaultBlockSize
) (
   input  logic                   clk,
   input  logic                   h_Disp,
   input  clockDisplayPkg::coordT cellX,
   input  clockDisplayPkg::coordT cellY,
   input  clockDisplayPkg::digitT cellDigit,
   input  logic                   inCell,
   input  clockDisplayPkg::coordT inX,
   input  clockDisplayPkg::coordT inY,
   output logic                   pixOn,
   output clockDisplayPkg::coordT pixX,
   output clockDisplayPkg::coordT pixY
);

   import clockDisplayPkg::*;

   segMaskT segMask;
   segMaskT segArea;
   logic    lit;

   // bar test in block units, inclusive on both sides
   function automatic logic inBar(input coordT x, input coordT y,
                                  input int x0, input int x1,
                                  input int y0, input int y1);
      return (x >= coordT'(x0 * blockSize)) && (x <= coordT'(x1 * blockSize))
          && (y >= coordT'(y0 * blockSize)) && (y <= coordT'(y1 * blockSize));
   endfunction

   // seven segment decode, bits a..g
   always_comb begin
      case (cellDigit)
         4'd0:    segMask = 7'b1111110;
         4'd1:    segMask = 7'b0110000;
         4'd2:    segMask = 7'b1101101;
         4'd3:    segMask = 7'b1111001;
         4'd4:    segMask = 7'b0110011;
         4'd5:    segMask = 7'b1011011;
         4'd6:    segMask = 7'b1011111;
         4'd7:    segMask = 7'b1110000;
         4'd8:    segMask = 7'b1111111;
         4'd9:    segMask = 7'b1111011;
         // 10 to 15 blank
         default: segMask = 7'b0000000;
      endcase
   end

   // which bars cover the local coordinate
   always_comb begin
      segArea       = '0;
      // top, upper right, lower right
      segArea[segA] = inBar(cellX, cellY, 1, 4, 0, 1);
      segArea[segB] = inBar(cellX, cellY, 4, 5, 1, 4);
      segArea[segC] = inBar(cellX, cellY, 4, 5, 5, 8);
      // bottom, lower left, upper left
      segArea[segD] = inBar(cellX, cellY, 1, 4, 8, 9);
      segArea[segE] = inBar(cellX, cellY, 0, 1, 5, 8);
      segArea[segF] = inBar(cellX, cellY, 0, 1, 1, 4);
      // middle bar
      segArea[segG] = inBar(cellX, cellY, 1, 4, 4, 5);
   end

   // lit only inside a cell on an enabled bar
   assign lit = inCell && (|(segMask & segArea));

   always_ff @(posedge clk or posedge h_Disp) begin
      if (h_Disp) begin
         pixOn <= 1'b0;
         pixX  <= '0;
         pixY  <= '0;
      end else begin
         pixOn <= lit;
         pixX  <= inX;
         pixY  <= inY;
      end
   end

endmodule

`default_nettype wire
